//--- design/bomb_audio_pkg.sv
package bomb_audio_pkg;

  // one-cycle tick pulses, all from the same divider count
  typedef struct packed {
    logic base;
    logic fast;
    logic faster;
  } tick_strobes_t;

  // displayed countdown time m:ss
  typedef struct packed {
    logic [2:0] min;
    logic [2:0] sec_ten;
    logic [3:0] sec_one;
  } clock_time_t;

  // one tone: toggle spacing and toggle count (even, so audio ends low)
  typedef struct packed {
    logic [7:0] half_period;
    logic [9:0] toggles;
  } tone_cfg_t;

  // sound kinds, in falling priority
  typedef enum logic [1:0] {
    SND_ERROR,
    SND_BOOM,
    SND_PUZZLE,
    SND_TICK
  } sound_e;

  // tone table, half periods all distinct
  localparam tone_cfg_t TONE_ERROR  = '{half_period: 8'd12, toggles: 10'd10};
  localparam tone_cfg_t TONE_BOOM   = '{half_period: 8'd20, toggles: 10'd16};
  localparam tone_cfg_t TONE_PUZZLE = '{half_period: 8'd8, toggles: 10'd8};
  localparam tone_cfg_t TONE_TICK   = '{half_period: 8'd6, toggles: 10'd4};

  // tens-of-seconds limits for the tick zones at minute 0
  localparam logic [2:0] FAST_SEC_TEN   = 3'd3;
  localparam logic [2:0] FASTER_SEC_TEN = 3'd1;

  // tone table lookup by sound kind
  function automatic tone_cfg_t tone_of(sound_e kind);
    case (kind)
      SND_ERROR:  return TONE_ERROR;
      SND_BOOM:   return TONE_BOOM;
      SND_PUZZLE: return TONE_PUZZLE;
      default:    return TONE_TICK;
    endcase
  endfunction

endpackage

//--- design/strobe_divider.sv
`timescale 1ns/1ps

module strobe_divider
  import bomb_audio_pkg::*;
#(
  parameter int CLKS_PER_TICK = 200
) (
  input  logic          clk,
  input  logic          nrst,
  input  logic          start,
  output tick_strobes_t strobes
);

  localparam int HALF    = CLKS_PER_TICK / 2;
  localparam int QUARTER = CLKS_PER_TICK / 4;
  localparam int CW      = $clog2(CLKS_PER_TICK);

  logic [CW-1:0] cnt;
  logic          at_full;
  logic          at_half;
  logic          at_quarter;

  // wrap points of the single counter
  assign at_full = (cnt == CW'(CLKS_PER_TICK - 1));
  // half and quarter wraps decoded from the count on their own
  assign at_half    = ((int'(cnt) % HALF) == HALF - 1);
  assign at_quarter = ((int'(cnt) % QUARTER) == QUARTER - 1);

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      cnt     <= '0;
      strobes <= '0;
    end else if (start) begin
      // restart so the first base lands a full period after start
      cnt     <= '0;
      strobes <= '0;
    end else begin
      if (at_full) begin
        cnt <= '0;
      end else begin
        cnt <= cnt + CW'(1);
      end
      // registered strobes, one cycle wide
      strobes.base   <= at_full;
      strobes.fast   <= at_half;
      strobes.faster <= at_quarter;
    end
  end

  // all three strobes stay phase aligned
  a_base_aligned: assert property (
    @(posedge clk) disable iff (!nrst)
    strobes.base |-> (strobes.fast && strobes.faster)
  );

endmodule

//--- design/countdown_timer.sv
`timescale 1ns/1ps

module countdown_timer
  import bomb_audio_pkg::*;
#(
  parameter int START_MIN = 1
) (
  input  logic        clk,
  input  logic        nrst,
  input  logic        tick,
  input  logic        start,
  input  logic        freeze,
  output clock_time_t time_now,
  output logic        running,
  output logic        expired,
  output logic        expire_pulse
);

  localparam clock_time_t LOAD_TIME = '{min: 3'(START_MIN), sec_ten: 3'd0, sec_one: 4'd0};

  clock_time_t dec_time;
  logic        dec_zero;

  // mixed radix decrement: 9..0 seconds, 5..0 tens, then minutes
  always_comb begin
    dec_time = time_now;
    if (time_now.sec_one != 4'd0) begin
      dec_time.sec_one = time_now.sec_one - 4'd1;
    end else begin
      dec_time.sec_one = 4'd9;
      if (time_now.sec_ten != 3'd0) begin
        dec_time.sec_ten = time_now.sec_ten - 3'd1;
      end else begin
        // borrow from minutes
        dec_time.sec_ten = 3'd5;
        dec_time.min     = time_now.min - 3'd1;
      end
    end
  end

  assign dec_zero = (dec_time == '0);

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      time_now     <= LOAD_TIME;
      running      <= 1'b0;
      expired      <= 1'b0;
      expire_pulse <= 1'b0;
    end else begin
      expire_pulse <= 1'b0;
      if (start) begin
        // reload and run, a new game
        time_now <= LOAD_TIME;
        running  <= 1'b1;
        expired  <= 1'b0;
      end else if (freeze) begin
        // game cleared, hold display as is
        running <= 1'b0;
      end else if (running && tick) begin
        time_now <= dec_time;
        if (dec_zero) begin
          // reached 0:00
          running      <= 1'b0;
          expired      <= 1'b1;
          expire_pulse <= 1'b1;
        end
      end
    end
  end

  // display digits stay in range
  a_digits_valid: assert property (
    @(posedge clk) disable iff (!nrst)
    (time_now.sec_one <= 4'd9) && (time_now.sec_ten <= 3'd5)
  );

endmodule

//--- design/sound_sequencer.sv
`timescale 1ns/1ps

module sound_sequencer
  import bomb_audio_pkg::*;
(
  input  logic          clk,
  input  logic          nrst,
  input  tick_strobes_t strobes,
  input  clock_time_t   time_now,
  input  logic          running,
  input  logic          error,
  input  logic          puzzle_clear,
  input  logic          game_clear,
  input  logic          expire_pulse,
  output logic          tone_req,
  output tone_cfg_t     tone_cfg,
  input  logic          tone_ack
);

  typedef enum logic [1:0] {
    IDLE,
    REQ,
    RELEASE
  } state_t;

  state_t     state;
  logic       tick_sel;
  logic [3:0] pending;
  logic [3:0] pending_next;
  logic [3:0] set_vec;
  logic [3:0] req_vec;
  logic [3:0] grant_mask;
  logic       grant;
  sound_e     grant_kind;

  // tick speed by zone, only at minute 0
  always_comb begin
    if (time_now.min == 3'd0 && time_now.sec_ten <= FASTER_SEC_TEN) begin
      tick_sel = strobes.faster;
    end else if (time_now.min == 3'd0 && time_now.sec_ten <= FAST_SEC_TEN) begin
      tick_sel = strobes.fast;
    end else begin
      tick_sel = strobes.base;
    end
  end

  // new events this cycle, one bit per sound kind
  always_comb begin
    set_vec             = '0;
    set_vec[SND_ERROR]  = error;
    set_vec[SND_BOOM]   = game_clear | expire_pulse;
    set_vec[SND_PUZZLE] = puzzle_clear;
    // no ticks once the clock stops
    set_vec[SND_TICK]   = running & tick_sel & ~game_clear;
  end

  // a tick left over from before the stop is never played
  always_comb begin
    req_vec           = pending;
    req_vec[SND_TICK] = pending[SND_TICK] & running;
  end

  // fixed priority, lowest enum value wins
  always_comb begin
    if (req_vec[SND_ERROR]) begin
      grant_kind = SND_ERROR;
    end else if (req_vec[SND_BOOM]) begin
      grant_kind = SND_BOOM;
    end else if (req_vec[SND_PUZZLE]) begin
      grant_kind = SND_PUZZLE;
    end else begin
      grant_kind = SND_TICK;
    end
  end

  assign grant      = (state == IDLE) && (|req_vec);
  assign grant_mask = grant ? (4'b0001 << grant_kind) : 4'b0000;

  // repeats merge, a fresh event on the grant cycle stays pending
  always_comb begin
    pending_next           = (pending & ~grant_mask) | set_vec;
    pending_next[SND_TICK] = pending_next[SND_TICK] & running;
  end

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      state    <= IDLE;
      tone_req <= 1'b0;
      pending  <= '0;
    end else begin
      pending <= pending_next;
      case (state)
        IDLE: begin
          if (grant) begin
            tone_req <= 1'b1;
            state    <= REQ;
          end
        end
        REQ: begin
          // tone finished
          if (tone_ack) begin
            tone_req <= 1'b0;
            state    <= RELEASE;
          end
        end
        RELEASE: begin
          // wait for ack low before the next request
          if (!tone_ack) begin
            state <= IDLE;
          end
        end
        default: begin
          state    <= IDLE;
          tone_req <= 1'b0;
        end
      endcase
    end
  end

  // tone payload, loaded only at grant
  always_ff @(posedge clk) begin
    if (grant) begin
      tone_cfg <= tone_of(grant_kind);
    end
  end

  // req may only drop after the tone generator acked
  a_req_held: assert property (
    @(posedge clk) disable iff (!nrst)
    $fell(tone_req) |-> $past(tone_ack)
  );

  // payload frozen for the whole request
  a_cfg_stable: assert property (
    @(posedge clk) disable iff (!nrst)
    (tone_req && $past(tone_req)) |-> $stable(tone_cfg)
  );

endmodule

//--- design/tone_gen.sv
`timescale 1ns/1ps

module tone_gen
  import bomb_audio_pkg::*;
(
  input  logic      clk,
  input  logic      nrst,
  input  logic      req,
  input  tone_cfg_t cfg,
  output logic      ack,
  output logic      audio
);

  logic       busy;
  logic [7:0] hp_cnt;
  logic [9:0] tog_cnt;
  logic       hp_done;
  logic       last_toggle;

  // half period elapsed, toggle now
  assign hp_done     = (hp_cnt == cfg.half_period);
  assign last_toggle = hp_done && ((tog_cnt + 10'd1) == cfg.toggles);

  always_ff @(posedge clk, negedge nrst) begin
    if (!nrst) begin
      busy    <= 1'b0;
      ack     <= 1'b0;
      audio   <= 1'b0;
      hp_cnt  <= '0;
      tog_cnt <= '0;
    end else if (busy) begin
      if (hp_done) begin
        audio   <= ~audio;
        hp_cnt  <= 8'd1;
        tog_cnt <= tog_cnt + 10'd1;
        // even toggle count, audio is low again here
        if (last_toggle) begin
          busy <= 1'b0;
          ack  <= 1'b1;
        end
      end else begin
        hp_cnt <= hp_cnt + 8'd1;
      end
    end else if (ack) begin
      // hold ack until the sequencer drops req
      audio <= 1'b0;
      if (!req) begin
        ack <= 1'b0;
      end
    end else begin
      // idle, silent until a new request
      audio <= 1'b0;
      if (req) begin
        busy    <= 1'b1;
        hp_cnt  <= 8'd1;
        tog_cnt <= '0;
      end
    end
  end

  // speaker is silent whenever a tone is reported done
  a_quiet_on_ack: assert property (
    @(posedge clk) disable iff (!nrst)
    ack |-> !audio
  );

endmodule

//--- design/bomb_audio_top.sv
`timescale 1ns/1ps

module bomb_audio_top
  import bomb_audio_pkg::*;
#(
  parameter int CLKS_PER_TICK = 200,
  parameter int START_MIN     = 1
) (
  input  logic        clk,
  input  logic        nrst,
  input  logic        start,
  input  logic        error,
  input  logic        puzzle_clear,
  input  logic        game_clear,
  output logic        audio,
  output clock_time_t time_now,
  output logic        expired
);

  tick_strobes_t strobes;
  logic          running;
  logic          expire_pulse;
  logic          tone_req;
  logic          tone_ack;
  tone_cfg_t     tone_cfg;

  // tick strobes, restarted with the countdown
  strobe_divider #(
    .CLKS_PER_TICK(CLKS_PER_TICK)
  ) u_strobe_divider (
    .clk    (clk),
    .nrst   (nrst),
    .start  (start),
    .strobes(strobes)
  );

  // game clear freezes the display
  countdown_timer #(
    .START_MIN(START_MIN)
  ) u_countdown_timer (
    .clk         (clk),
    .nrst        (nrst),
    .tick        (strobes.base),
    .start       (start),
    .freeze      (game_clear),
    .time_now    (time_now),
    .running     (running),
    .expired     (expired),
    .expire_pulse(expire_pulse)
  );

  sound_sequencer u_sound_sequencer (
    .clk         (clk),
    .nrst        (nrst),
    .strobes     (strobes),
    .time_now    (time_now),
    .running     (running),
    .error       (error),
    .puzzle_clear(puzzle_clear),
    .game_clear  (game_clear),
    .expire_pulse(expire_pulse),
    .tone_req    (tone_req),
    .tone_cfg    (tone_cfg),
    .tone_ack    (tone_ack)
  );

  // req/ack handshake with the sequencer
  tone_gen u_tone_gen (
    .clk  (clk),
    .nrst (nrst),
    .req  (tone_req),
    .cfg  (tone_cfg),
    .ack  (tone_ack),
    .audio(audio)
  );

endmodule

//--- verification/tb_bomb_audio.sv
`timescale 1ns/1ps

module tb_bomb_audio;
  import bomb_audio_pkg::*;

  localparam int CLKS      = 200;
  localparam int START_MIN = 1;

  logic        clk = 1'b0;
  logic        nrst;
  logic        start;
  logic        error;
  logic        puzzle_clear;
  logic        game_clear;
  logic        audio;
  clock_time_t time_now;
  logic        expired;

  integer      seed;
  int          cyc;
  // burst monitor state
  logic        prev_audio;
  int          edge_cnt;
  int          last_edge;
  int          half;
  // model state
  sound_e      exp_q[$];
  int          model_sec;
  int          last_change;
  clock_time_t disp_prev;
  bit          track;
  bit          check_ticks;
  int          tick_window;
  int          ticks_total;
  // result counters
  int          total_errs;
  int          test_errs;
  int          tests_run;
  int          tests_failed;

  bomb_audio_top #(
    .CLKS_PER_TICK(CLKS),
    .START_MIN    (START_MIN)
  ) u_bomb_audio_top (
    .clk         (clk),
    .nrst        (nrst),
    .start       (start),
    .error       (error),
    .puzzle_clear(puzzle_clear),
    .game_clear  (game_clear),
    .audio       (audio),
    .time_now    (time_now),
    .expired     (expired)
  );

  always #2 clk = ~clk;

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
      test_errs++;
      total_errs++;
    end
  endtask

  task automatic note_failure(string msg);
    $display("%s", msg);
    test_errs++;
    total_errs++;
  endtask

  task automatic end_test(string name);
    tests_run++;
    if (test_errs == 0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: FAILED with %0d errors", name, test_errs);
      tests_failed++;
    end
    test_errs = 0;
  endtask

  // m:ss display of a second count
  function automatic clock_time_t to_clock(int s);
    clock_time_t t;
    t.min     = 3'(s / 60);
    t.sec_ten = 3'((s % 60) / 10);
    t.sec_one = 4'(s % 10);
    return t;
  endfunction

  // ticks per display interval: 1 from 0:40 up, 2 below 0:40, 4 below 0:20
  function automatic int ticks_for_sec(int s);
    if (s < 20) begin
      return 4;
    end else if (s < 40) begin
      return 2;
    end
    return 1;
  endfunction

  // half period identifies the sound, -1 if none matches
  function automatic int kind_of_hp(int hp);
    if (hp == int'(TONE_ERROR.half_period)) return int'(SND_ERROR);
    if (hp == int'(TONE_BOOM.half_period)) return int'(SND_BOOM);
    if (hp == int'(TONE_PUZZLE.half_period)) return int'(SND_PUZZLE);
    if (hp == int'(TONE_TICK.half_period)) return int'(SND_TICK);
    return -1;
  endfunction

  function automatic int toggles_of(sound_e kind);
    case (kind)
      SND_ERROR:  return int'(TONE_ERROR.toggles);
      SND_BOOM:   return int'(TONE_BOOM.toggles);
      SND_PUZZLE: return int'(TONE_PUZZLE.toggles);
      default:    return int'(TONE_TICK.toggles);
    endcase
  endfunction

  task automatic record_burst(int hp, int edges);
    int     k;
    sound_e kind;
    sound_e want;
    k = kind_of_hp(hp);
    if (k < 0) begin
      note_failure($sformatf("audio burst with unknown half period of %0d cycles", hp));
    end else begin
      kind = sound_e'(k);
      check_value("burst_edges", 32'(edges), 32'(toggles_of(kind)));
      if (kind == SND_TICK) begin
        // ticks only counted, never queued
        tick_window++;
        ticks_total++;
      end else if (exp_q.size() == 0) begin
        note_failure($sformatf("%s burst played with no event pending", kind.name()));
      end else begin
        want = exp_q.pop_front();
        check_value("burst_kind", 32'(kind), 32'(want));
      end
    end
  endtask

  // burst ends on the first gap that differs from its half period
  task automatic sample_audio();
    if (audio !== prev_audio) begin
      if (edge_cnt == 0) begin
        edge_cnt = 1;
      end else if (edge_cnt == 1) begin
        half     = cyc - last_edge;
        edge_cnt = 2;
      end else if (cyc - last_edge == half) begin
        edge_cnt++;
      end else begin
        record_burst(half, edge_cnt);
        edge_cnt = 1;
      end
      last_edge = cyc;
    end else if (edge_cnt >= 2 && cyc - last_edge > half) begin
      record_burst(half, edge_cnt);
      edge_cnt = 0;
    end
    prev_audio = audio;
  endtask

  task automatic watch_display();
    if (time_now !== disp_prev) begin
      if (track) begin
        // interval that just ended showed model_sec
        if (check_ticks && last_change >= 0) begin
          check_value("tick_bursts", 32'(tick_window), 32'(ticks_for_sec(model_sec)));
        end
        model_sec--;
        check_value("time_now", 32'(time_now), 32'(to_clock(model_sec)));
        if (last_change >= 0) begin
          check_value("change_interval", 32'(cyc - last_change), 32'(CLKS));
        end
      end
      tick_window = 0;
      last_change = cyc;
      disp_prev   = time_now;
    end
  endtask

  // one clock, inputs may be driven right after
  task automatic step();
    @(negedge clk);
    cyc++;
    sample_audio();
    watch_display();
  endtask

  task automatic start_game();
    track = 1'b0;
    start = 1'b1;
    step();
    start       = 1'b0;
    model_sec   = START_MIN * 60;
    disp_prev   = time_now;
    last_change = -1;
    tick_window = 0;
    check_value("time_now", 32'(time_now), 32'(to_clock(model_sec)));
    track = 1'b1;
  endtask

  task automatic run_down_to(int target);
    int n;
    int limit;
    n     = 0;
    limit = (model_sec - target + 2) * CLKS;
    while (model_sec > target && n < limit) begin
      step();
      n++;
    end
    if (model_sec > target) begin
      note_failure($sformatf("timeout: countdown stuck at %0d seconds", model_sec));
    end
  endtask

  task automatic wait_queue_empty(int limit, string what);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit) begin
      step();
      n++;
    end
    if (exp_q.size() != 0) begin
      note_failure($sformatf("timeout: %s never played, %0d missing", what, exp_q.size()));
      exp_q.delete();
    end
  endtask

  // no tick and no display change for a few intervals
  task automatic check_silent(clock_time_t hold);
    int ticks_before;
    ticks_before = ticks_total;
    repeat (3 * CLKS) step();
    check_value("tick_bursts_after_stop", 32'(ticks_total - ticks_before), 32'd0);
    check_value("time_now", 32'(time_now), 32'(hold));
  endtask

  initial begin
    clock_time_t frozen;
    int          gap;
    int          kind;
    int          n;
    int          limit;
    nrst         = 1'b0;
    start        = 1'b0;
    error        = 1'b0;
    puzzle_clear = 1'b0;
    game_clear   = 1'b0;
    seed         = 32'heb57;
    cyc          = 0;
    prev_audio   = 1'b0;
    edge_cnt     = 0;
    track        = 1'b0;
    check_ticks  = 1'b0;
    ticks_total  = 0;

    // reset state
    repeat (10) step();
    nrst = 1'b1;
    step();
    check_value("audio", 32'(audio), 32'd0);
    check_value("expired", 32'(expired), 32'd0);
    check_value("time_now", 32'(time_now), 32'(to_clock(START_MIN * 60)));
    end_test("reset_state");

    // countdown alone, then with per-interval tick counts
    start_game();
    run_down_to(45);
    end_test("countdown");
    check_ticks = 1'b1;
    run_down_to(12);
    check_ticks = 1'b0;
    end_test("tick_accel");

    // game clear freezes the clock and plays one boom
    track      = 1'b0;
    game_clear = 1'b1;
    exp_q.push_back(SND_BOOM);
    step();
    game_clear = 1'b0;
    frozen     = time_now;
    wait_queue_empty(1000, "boom after game clear");
    check_silent(frozen);
    check_value("expired", 32'(expired), 32'd0);
    end_test("game_clear");

    // new game, random error and puzzle pulses, 2 means both at once
    start_game();
    for (int i = 0; i < 12; i++) begin
      gap = 300 + int'($unsigned($random(seed)) % 128);
      repeat (gap) step();
      kind = int'($unsigned($random(seed)) % 3);
      // first event always both at once
      if (i == 0) begin
        kind = 2;
      end
      error        = (kind != 1);
      puzzle_clear = (kind != 0);
      if (error) begin
        exp_q.push_back(SND_ERROR);
      end
      if (puzzle_clear) begin
        exp_q.push_back(SND_PUZZLE);
      end
      step();
      error        = 1'b0;
      puzzle_clear = 1'b0;
    end
    wait_queue_empty(1000, "event sounds");
    end_test("random_events");

    // same game runs out
    n     = 0;
    limit = (model_sec + 2) * CLKS;
    while (expired !== 1'b1 && n < limit) begin
      step();
      n++;
    end
    if (expired !== 1'b1) begin
      note_failure("timeout: expired never rose");
    end else begin
      exp_q.push_back(SND_BOOM);
      check_value("time_now", 32'(time_now), 32'(to_clock(0)));
      wait_queue_empty(1000, "boom after expiry");
      check_silent(to_clock(0));
      check_value("expired", 32'(expired), 32'd1);
    end
    end_test("expiry");

    $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errs);
    if (total_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- build.f
design/bomb_audio_pkg.sv
design/strobe_divider.sv
design/countdown_timer.sv
design/sound_sequencer.sv
design/tone_gen.sv
design/bomb_audio_top.sv
verification/tb_bomb_audio.sv

//--- Makefile
# Verilator build and run of the bomb audio testbench

SIM      ?= verilator
TOP      ?= tb_bomb_audio
FILELIST ?= build.f
OBJ_DIR  ?= obj_dir
LOG      ?= sim.log
VFLAGS   ?= --binary --timing --assert -j 0
PASS_MSG ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(SIM) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
